//--- core_region.f
+incdir+verif
rtl/core_region_pkg.sv
rtl/lsu_bus_if.sv
rtl/sram_if.sv
rtl/lsu_demux.sv
rtl/ram_port_mux.sv
rtl/data_sram.sv
rtl/core_region.sv
verif/core_region_tb.sv

//--- rtl/core_region.sv
// ---------------------------------------------------------------------
// core region load/store path
// core port decoded onto a local 64-bit data RAM or the external bus;
// the RAM is shared with a wide slave port of higher priority
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_region #(
  parameter int RAM_WORDS = 256
) (
  input  wire logic                               clk,
  input  wire logic                               rst_n,

  // core load/store port
  input  wire logic                               core_req_i,
  input  wire logic [core_region_pkg::ADDR_W-1:0]     core_addr_i,
  input  wire logic                               core_we_i,
  input  wire logic [core_region_pkg::CORE_BW-1:0]    core_be_i,
  input  wire logic [core_region_pkg::CORE_DW-1:0]    core_wdata_i,
  output logic                                    core_gnt_o,
  output logic                                    core_rvalid_o,
  output logic [core_region_pkg::CORE_DW-1:0]     core_rdata_o,

  // external bus
  output logic                                    ext_req_o,
  output logic [core_region_pkg::ADDR_W-1:0]      ext_addr_o,
  output logic                                    ext_we_o,
  output logic [core_region_pkg::CORE_BW-1:0]     ext_be_o,
  output logic [core_region_pkg::CORE_DW-1:0]     ext_wdata_o,
  input  wire logic                               ext_gnt_i,
  input  wire logic                               ext_rvalid_i,
  input  wire logic [core_region_pkg::CORE_DW-1:0]    ext_rdata_i,

  // wide RAM slave port, word addressed
  input  wire logic                               slv_req_i,
  input  wire logic [$clog2(RAM_WORDS)-1:0]       slv_addr_i,
  input  wire logic                               slv_we_i,
  input  wire logic [core_region_pkg::RAM_BW-1:0]     slv_be_i,
  input  wire logic [core_region_pkg::RAM_DW-1:0]     slv_wdata_i,
  output logic [core_region_pkg::RAM_DW-1:0]      slv_rdata_o
);

  // decoder to RAM mux
  lsu_bus_if i_ram_bus ();

  // RAM mux to data RAM
  sram_if #(
    .RAM_WORDS (RAM_WORDS)
  ) i_sram_bus ();

  lsu_demux i_lsu_demux (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (core_req_i),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .ext_req_o     (ext_req_o),
    .ext_addr_o    (ext_addr_o),
    .ext_we_o      (ext_we_o),
    .ext_be_o      (ext_be_o),
    .ext_wdata_o   (ext_wdata_o),
    .ext_gnt_i     (ext_gnt_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_rdata_i   (ext_rdata_i),
    .ram           (i_ram_bus.master)
  );

  ram_port_mux #(
    .RAM_WORDS (RAM_WORDS)
  ) i_ram_port_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_req_i   (slv_req_i),
    .slv_addr_i  (slv_addr_i),
    .slv_we_i    (slv_we_i),
    .slv_be_i    (slv_be_i),
    .slv_wdata_i (slv_wdata_i),
    .slv_rdata_o (slv_rdata_o),
    .core        (i_ram_bus.slave),
    .mem         (i_sram_bus.master)
  );

  data_sram #(
    .RAM_WORDS (RAM_WORDS)
  ) i_data_sram (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (i_sram_bus.slave)
  );

endmodule

`default_nettype wire

//--- rtl/core_region_pkg.sv
// ---------------------------------------------------------------------
// core region package
// widths, address map of the local RAM window and the RAM word type
// shared by the load/store path
// ---------------------------------------------------------------------
`default_nettype none

package core_region_pkg;

  // core side of the load/store unit
  localparam int ADDR_W  = 32;
  localparam int CORE_DW = 32;
  localparam int CORE_BW = CORE_DW / 8;

  // local data RAM word
  localparam int RAM_DW = 64;
  localparam int RAM_BW = RAM_DW / 8;
  localparam int LANES  = RAM_DW / CORE_DW;

  // byte address fields
  localparam int LANE_LSB   = 2;
  localparam int WORD_LSB   = 3;
  localparam int REGION_LSB = 20;

  // addresses with this tag in bits 31..20 hit the local RAM
  localparam logic [ADDR_W-REGION_LSB-1:0] RAM_REGION_TAG = 12'h001;

  // one RAM word, seen whole by the slave port and per lane by the core
  // lane 0 sits in the low half
  typedef union packed {
    logic [RAM_DW-1:0]             word;
    logic [LANES-1:0][CORE_DW-1:0] lane;
  } ram_word_u;

endpackage

`default_nettype wire

//--- rtl/data_sram.sv
// ---------------------------------------------------------------------
// data RAM
// single-port, byte-enabled, 64-bit words, one-cycle read latency
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int RAM_WORDS = 256
) (
  input  wire logic clk,
  input  wire logic rst_n,
  sram_if.slave     mem
);
  import core_region_pkg::*;

  logic [RAM_DW-1:0] ram_q [RAM_WORDS];

  // byte-masked write
  always_ff @(posedge clk) begin
    if (mem.en && mem.we) begin
      for (int b = 0; b < RAM_BW; b++) begin
        if (mem.be[b]) begin
          ram_q[mem.addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read port, holds its value between reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem.rdata <= '0;
    end else if (mem.en && !mem.we) begin
      mem.rdata <= ram_q[mem.addr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_bus_if.sv
// ---------------------------------------------------------------------
// load/store bus
// core-side req/gnt/rvalid channel between decoder and RAM mux
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface lsu_bus_if;
  import core_region_pkg::*;

  // request
  logic               req;
  logic               gnt;
  logic [ADDR_W-1:0]  addr;
  logic               we;
  logic [CORE_BW-1:0] be;
  logic [CORE_DW-1:0] wdata;

  // response, one rvalid per accepted request
  logic               rvalid;
  logic [CORE_DW-1:0] rdata;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

//--- rtl/lsu_demux.sv
// ---------------------------------------------------------------------
// load/store address decoder
// steers core requests to the local RAM or the external port and
// routes the matching response back
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_demux (
  input  wire logic                            clk,
  input  wire logic                            rst_n,

  // core side
  input  wire logic                            core_req_i,
  input  wire logic [core_region_pkg::ADDR_W-1:0]  core_addr_i,
  input  wire logic                            core_we_i,
  input  wire logic [core_region_pkg::CORE_BW-1:0] core_be_i,
  input  wire logic [core_region_pkg::CORE_DW-1:0] core_wdata_i,
  output logic                                 core_gnt_o,
  output logic                                 core_rvalid_o,
  output logic [core_region_pkg::CORE_DW-1:0]  core_rdata_o,

  // external bus
  output logic                                 ext_req_o,
  output logic [core_region_pkg::ADDR_W-1:0]   ext_addr_o,
  output logic                                 ext_we_o,
  output logic [core_region_pkg::CORE_BW-1:0]  ext_be_o,
  output logic [core_region_pkg::CORE_DW-1:0]  ext_wdata_o,
  input  wire logic                            ext_gnt_i,
  input  wire logic                            ext_rvalid_i,
  input  wire logic [core_region_pkg::CORE_DW-1:0] ext_rdata_i,

  // local RAM
  lsu_bus_if.master                            ram
);
  import core_region_pkg::*;

  logic is_ram;
  // high while the last request went outside the RAM window
  logic resp_ext_q;

  assign is_ram = (core_addr_i[ADDR_W-1:REGION_LSB] == RAM_REGION_TAG);

  // only one target sees the request
  assign ram.req   = core_req_i & is_ram;
  assign ext_req_o = core_req_i & ~is_ram;

  // address and write fields go to both targets unchanged
  assign ram.addr    = core_addr_i;
  assign ram.we      = core_we_i;
  assign ram.be      = core_be_i;
  assign ram.wdata   = core_wdata_i;
  assign ext_addr_o  = core_addr_i;
  assign ext_we_o    = core_we_i;
  assign ext_be_o    = core_be_i;
  assign ext_wdata_o = core_wdata_i;

  assign core_gnt_o = core_req_i & (is_ram ? ram.gnt : ext_gnt_i);

  // remember where the next response comes from
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_ext_q <= 1'b0;
    end else if (core_req_i) begin
      resp_ext_q <= ~is_ram;
    end
  end

  assign core_rdata_o  = resp_ext_q ? ext_rdata_i : ram.rdata;
  assign core_rvalid_o = ram.rvalid | ext_rvalid_i;

endmodule

`default_nettype wire

//--- rtl/ram_port_mux.sv
// ---------------------------------------------------------------------
// data RAM port mux
// fixed priority of the wide slave port over the core, and packing
// of the 32-bit core lanes into the 64-bit RAM word
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_port_mux #(
  parameter  int RAM_WORDS = 256,
  localparam int AW        = $clog2(RAM_WORDS)
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,

  // wide slave port, always taken
  input  wire logic                           slv_req_i,
  input  wire logic [AW-1:0]                  slv_addr_i,
  input  wire logic                           slv_we_i,
  input  wire logic [core_region_pkg::RAM_BW-1:0] slv_be_i,
  input  wire logic [core_region_pkg::RAM_DW-1:0] slv_wdata_i,
  output logic [core_region_pkg::RAM_DW-1:0]  slv_rdata_o,

  lsu_bus_if.slave                            core,
  sram_if.master                              mem
);
  import core_region_pkg::*;

  logic                          core_gnt;
  logic                          core_lane;
  logic                          lane_q;
  logic                          rvalid_q;
  ram_word_u                     core_wword;
  ram_word_u                     rd_word;
  logic [LANES-1:0][CORE_BW-1:0] core_be;

  // core only gets the RAM when the slave port is idle
  assign core_gnt = core.req & ~slv_req_i;
  assign core.gnt = core_gnt;

  assign core_lane = core.addr[LANE_LSB];

  // place core data and enables into the addressed lane
  always_comb begin
    core_wword.word    = '0;
    core_wword.lane[core_lane] = core.wdata;
    core_be            = '0;
    core_be[core_lane] = core.be;
  end

  assign mem.en    = slv_req_i | core.req;
  assign mem.addr  = slv_req_i ? slv_addr_i  : core.addr[WORD_LSB +: AW];
  assign mem.we    = slv_req_i ? slv_we_i    : core.we;
  assign mem.be    = slv_req_i ? slv_be_i    : core_be;
  assign mem.wdata = slv_req_i ? slv_wdata_i : core_wword.word;

  // one rvalid per core grant, one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= core_gnt;
    end
  end

  always_ff @(posedge clk) begin
    if (core_gnt) begin
      lane_q <= core_lane;
    end
  end

  // read data lines up with rvalid_q
  assign rd_word = mem.rdata;

  assign core.rvalid = rvalid_q;
  assign core.rdata  = rd_word.lane[lane_q];
  assign slv_rdata_o = rd_word.word;

endmodule

`default_nettype wire

//--- rtl/sram_if.sv
// ---------------------------------------------------------------------
// single-port RAM access
// enable, word address, byte enables, one-cycle read data
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface sram_if #(
  parameter int RAM_WORDS = 256
);
  import core_region_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  logic              en;
  logic [AW-1:0]     addr;
  logic              we;
  logic [RAM_BW-1:0] be;
  logic [RAM_DW-1:0] wdata;
  // valid the cycle after a read enable
  logic [RAM_DW-1:0] rdata;

  modport master (
    output en, addr, we, be, wdata,
    input  rdata
  );

  modport slave (
    input  en, addr, we, be, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- verif/core_region_ref.svh
// ----------------------------------------------------------------------
// core region reference model
// 64-bit RAM and external memory models with byte merging, expected
// read data, and the Galois LFSR for random stimulus
// ----------------------------------------------------------------------
`ifndef CORE_REGION_REF_SVH
`define CORE_REGION_REF_SVH

logic [31:0] lfsr_state = 32'h73f0bef3;
logic [63:0] ram_model [256];
logic [31:0] ext_model [logic [31:0]];

// one output bit per step, taps of x^32+x^22+x^2+x+1
function automatic logic lfsr_step();
  logic out_bit;
  out_bit    = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ 32'h8020_0003;
  end
  return out_bit;
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val = {val[30:0], lfsr_step()};
  end
  return val;
endfunction

function automatic bit in_ram_window(logic [31:0] addr);
  return addr[31:20] == 12'h001;
endfunction

// initial RAM contents depend on the whole word index
function automatic logic [63:0] ram_fill(int idx);
  logic [31:0] h;
  h = idx * 32'h9e37_79b9 + 32'h1234_5678;
  return {h ^ 32'hdead_0000, ~h};
endfunction

function automatic logic [31:0] ext_fill(logic [31:0] addr);
  return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
endfunction

// expected core read from the RAM model, lane picked by bit 2
function automatic logic [31:0] ram_lane_read(logic [31:0] addr);
  logic [63:0] w;
  w = ram_model[addr[10:3]];
  return addr[2] ? w[63:32] : w[31:0];
endfunction

function automatic void ram_core_write(logic [31:0] addr, logic [3:0] be,
                                       logic [31:0] data);
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      ram_model[addr[10:3]][addr[2]*32 + b*8 +: 8] = data[b*8 +: 8];
    end
  end
endfunction

function automatic void ram_slave_write(int idx, logic [7:0] be, logic [63:0] data);
  for (int b = 0; b < 8; b++) begin
    if (be[b]) begin
      ram_model[idx][b*8 +: 8] = data[b*8 +: 8];
    end
  end
endfunction

function automatic logic [31:0] ext_read(logic [31:0] addr);
  logic [31:0] key;
  key = {addr[31:2], 2'b00};
  return ext_model.exists(key) ? ext_model[key] : ext_fill(key);
endfunction

function automatic void ext_write(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
  logic [31:0] w;
  w = ext_read(addr);
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      w[b*8 +: 8] = data[b*8 +: 8];
    end
  end
  ext_model[{addr[31:2], 2'b00}] = w;
endfunction

`endif

//--- verif/core_region_tb.sv
// ----------------------------------------------------------------------
// core region testbench
// core, slave and external bus traffic checked against a byte model
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_region_tb;
  `include "core_region_ref.svh"

  localparam int N_TXN = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic core_req_i, core_we_i, core_gnt_o, core_rvalid_o;
  logic [31:0] core_addr_i, core_wdata_i, core_rdata_o;
  logic [3:0] core_be_i;
  logic ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  logic [31:0] ext_addr_o, ext_wdata_o, ext_rdata_i;
  logic [3:0] ext_be_o;
  logic slv_req_i, slv_we_i;
  logic [7:0] slv_addr_i, slv_be_i;
  logic [63:0] slv_wdata_i, slv_rdata_o;

  // {is_read, data} per accepted core request
  logic [32:0] exp_q [$];
  logic slv_chk_valid, prev_ram_gnt;
  logic [63:0] slv_chk_data;
  int ext_delay;
  int waits;

  core_region #(.RAM_WORDS(256)) i_dut (.*);

  initial begin
    forever #2 clk = ~clk;
  end

  task automatic fail_stop(string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  initial begin
    #(N_TXN * 64 * 4);
    $display("timeout: the test sequence did not complete in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  // drives one core request and waits for its grant
  task automatic core_issue(logic [31:0] addr, logic we, logic [3:0] be,
                            logic [31:0] wdata, output int n_wait);
    @(posedge clk);
    core_req_i <= 1'b1;
    core_addr_i <= addr;
    core_we_i <= we;
    core_be_i <= be;
    core_wdata_i <= wdata;
    n_wait = 1;
    @(negedge clk);
    while (!core_gnt_o) begin
      n_wait++;
      @(negedge clk);
    end
  endtask

  task automatic core_idle();
    @(posedge clk);
    core_req_i <= 1'b0;
  endtask

  task automatic wait_drained();
    @(posedge clk);
    while (exp_q.size() != 0 || slv_chk_valid) begin
      @(posedge clk);
    end
  endtask

  task automatic slave_op(int idx, logic we, logic [7:0] be, logic [63:0] data, int len);
    @(posedge clk);
    slv_req_i <= 1'b1;
    slv_addr_i <= idx[7:0];
    slv_we_i <= we;
    slv_be_i <= be;
    slv_wdata_i <= data;
    repeat (len) @(posedge clk);
    slv_req_i <= 1'b0;
  endtask

  function automatic logic [31:0] rand_ram_addr();
    return 32'h0010_0000 | (rand_bits(4) << 3) | (rand_bits(1) << 2);
  endfunction

  // external memory: grant after a random delay, respond one cycle later
  initial begin
    ext_delay = 0;
    forever begin
      @(posedge clk);
      ext_rvalid_i <= 1'b0;
      if (ext_req_o && ext_gnt_i) begin
        assert (ext_addr_o == core_addr_i)
        else fail_stop($sformatf("[FAIL] ext_addr_o exp %h got %h", core_addr_i, ext_addr_o));
        assert (ext_we_o == core_we_i)
        else fail_stop($sformatf("[FAIL] ext_we_o exp %h got %h", core_we_i, ext_we_o));
        assert (ext_be_o == core_be_i)
        else fail_stop($sformatf("[FAIL] ext_be_o exp %h got %h", core_be_i, ext_be_o));
        assert (ext_wdata_o == core_wdata_i)
        else fail_stop($sformatf("[FAIL] ext_wdata_o exp %h got %h",
                                 core_wdata_i, ext_wdata_o));
        ext_gnt_i <= 1'b0;
        ext_rvalid_i <= 1'b1;
        ext_rdata_i <= ext_we_o ? rand_bits(32) : ext_read(ext_addr_o);
        ext_delay = rand_bits(2);
      end else if (ext_req_o) begin
        if (ext_delay == 0) begin
          ext_gnt_i <= 1'b1;
        end else begin
          ext_delay--;
        end
      end
    end
  end

  // compare process, sampled at the falling edge
  always @(negedge clk) begin
    logic [32:0] e;
    assert (core_req_i || !ext_req_o)
    else fail_stop("ext_req_o raised without a core request");
    if (!rst_n) begin
      assert (!core_rvalid_o)
      else fail_stop("core_rvalid_o high during reset");
    end
    if (slv_chk_valid) begin
      assert (slv_rdata_o == slv_chk_data)
      else fail_stop($sformatf("[FAIL] slv_rdata_o exp %h got %h", slv_chk_data, slv_rdata_o));
    end
    slv_chk_valid = slv_req_i && !slv_we_i;
    slv_chk_data = ram_model[slv_addr_i];
    if (slv_req_i && slv_we_i) begin
      ram_slave_write(slv_addr_i, slv_be_i, slv_wdata_i);
    end
    if (prev_ram_gnt) begin
      assert (core_rvalid_o)
      else fail_stop("core_rvalid_o missing one cycle after a RAM grant");
    end
    if (core_rvalid_o) begin
      assert (exp_q.size() != 0)
      else fail_stop("core_rvalid_o without an outstanding request");
      e = exp_q.pop_front();
      assert (!e[32] || core_rdata_o == e[31:0])
      else fail_stop($sformatf("[FAIL] core_rdata_o exp %h got %h", e[31:0], core_rdata_o));
    end
    if (core_req_i && in_ram_window(core_addr_i) && rst_n) begin
      assert (core_gnt_o == !slv_req_i)
      else fail_stop($sformatf("[FAIL] core_gnt_o exp %h got %h", !slv_req_i, core_gnt_o));
    end
    prev_ram_gnt = core_gnt_o && in_ram_window(core_addr_i);
    if (core_gnt_o) begin
      if (in_ram_window(core_addr_i)) begin
        if (core_we_i) ram_core_write(core_addr_i, core_be_i, core_wdata_i);
        exp_q.push_back({!core_we_i, ram_lane_read(core_addr_i)});
      end else begin
        if (core_we_i) ext_write(core_addr_i, core_be_i, core_wdata_i);
        exp_q.push_back({!core_we_i, ext_read(core_addr_i)});
      end
    end
  end

  initial begin
    logic [31:0] a;
    logic [63:0] w;
    int idx;
    rst_n = 1'b0;
    {core_req_i, core_we_i, core_addr_i, core_be_i, core_wdata_i} = '0;
    {ext_gnt_i, ext_rvalid_i, ext_rdata_i} = '0;
    {slv_req_i, slv_we_i, slv_addr_i, slv_be_i, slv_wdata_i} = '0;
    {slv_chk_valid, prev_ram_gnt} = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // fill the used RAM words, then read a few back on the slave port
    for (int i = 0; i < 16; i++) slave_op(i, 1'b1, 8'hff, ram_fill(i), 1);
    for (int i = 0; i < 4; i++) slave_op(i, 1'b0, 8'h00, '0, 1);
    // random core writes and reads in the RAM window
    for (int i = 0; i < 40; i++) begin
      core_issue(rand_ram_addr(), 1'b1, rand_bits(4), rand_bits(32), waits);
    end
    for (int i = 0; i < 40; i++) core_issue(rand_ram_addr(), 1'b0, 4'h0, '0, waits);
    core_idle();
    wait_drained();
    // back-to-back reads, one grant per cycle
    for (int i = 0; i < 8; i++) begin
      core_issue(rand_ram_addr(), 1'b0, 4'h0, '0, waits);
      assert (waits == 1)
      else fail_stop("back-to-back core read was not granted in its first cycle");
    end
    core_idle();
    wait_drained();
    // external accesses, write then read back the same address
    for (int i = 0; i < 20; i++) begin
      a = rand_bits(32);
      if (in_ram_window(a)) a[31] = 1'b1;
      core_issue(a, 1'b1, rand_bits(4), rand_bits(32), waits);
      core_idle();
      wait_drained();
      core_issue(a, 1'b0, 4'h0, '0, waits);
      core_idle();
      wait_drained();
    end
    for (int i = 0; i < 16; i++) core_issue(rand_ram_addr(), 1'b0, 4'h0, '0, waits);
    core_idle();
    wait_drained();
    // slave port holds off the core
    for (int i = 0; i < 4; i++) begin
      fork
        slave_op(rand_bits(4), 1'b0, 8'h00, '0, 3);
        core_issue(rand_ram_addr(), 1'b0, 4'h0, '0, waits);
      join
      core_idle();
      wait_drained();
    end
    // lane view of a slave write, then slave view of a core lane write
    for (int i = 0; i < 4; i++) begin
      idx = rand_bits(4);
      w = {rand_bits(32), rand_bits(32)};
      slave_op(idx, 1'b1, 8'hff, w, 1);
      core_issue(32'h0010_0000 | (idx << 3), 1'b0, 4'h0, '0, waits);
      core_issue(32'h0010_0004 | (idx << 3), 1'b0, 4'h0, '0, waits);
      core_issue(32'h0010_0000 | (idx << 3) | (i[0] << 2), 1'b1, 4'hf, rand_bits(32), waits);
      core_idle();
      wait_drained();
      slave_op(idx, 1'b0, 8'h00, '0, 1);
      wait_drained();
    end
    repeat (4) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
